// File: rtl/rv_decode_consts.svh
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// Major opcodes.
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_IMM     7'b0010011
`define OPC_REG     7'b0110011
`define OPC_FENCE   7'b0001111
`define OPC_SYSTEM  7'b1110011

// Branch conditions.
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// Access sizes, shared by loads and stores.
`define F3_B        3'b000
`define F3_H        3'b001
`define F3_W        3'b010
`define F3_BU       3'b100
`define F3_HU       3'b101

// Integer ALU, immediate and register forms.
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// M extension.
`define F3_MUL      3'b000
`define F3_MULH     3'b001
`define F3_MULHSU   3'b010
`define F3_MULHU    3'b011
`define F3_DIV      3'b100
`define F3_DIVU     3'b101
`define F3_REM      3'b110
`define F3_REMU     3'b111

`define F3_FENCE    3'b000
`define F3_FENCE_I  3'b001

// System space.
`define F3_PRIV     3'b000
`define F3_CSRRW    3'b001
`define F3_CSRRS    3'b010
`define F3_CSRRC    3'b011
`define F3_CSRRWI   3'b101
`define F3_CSRRSI   3'b110
`define F3_CSRRCI   3'b111

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000
`define F7_MULDIV   7'b0000001

`define SYS_ECALL   12'h000
`define SYS_EBREAK  12'h001
`define SYS_MRET    12'h302
`define SYS_WFI     12'h105

// Canonical nop is addi x0, x0, 0.
`define NOP_INSTR   32'h00000013

`define ALU_OP_W    10
`define BCU_OP_W    6
`define LSU_OP_W    8
`define CSR_OP_W    6
`define MUL_OP_W    4
`define DIV_OP_W    4

`define ALU_ADD     0
`define ALU_SUB     1
`define ALU_SLL     2
`define ALU_SLT     3
`define ALU_SLTU    4
`define ALU_XOR     5
`define ALU_SRL     6
`define ALU_SRA     7
`define ALU_OR      8
`define ALU_AND     9

`define BCU_BEQ     0
`define BCU_BNE     1
`define BCU_BLT     2
`define BCU_BGE     3
`define BCU_BLTU    4
`define BCU_BGEU    5

`define LSU_LB      0
`define LSU_LH      1
`define LSU_LW      2
`define LSU_LBU     3
`define LSU_LHU     4
`define LSU_SB      5
`define LSU_SH      6
`define LSU_SW      7

`define CSR_RW      0
`define CSR_RS      1
`define CSR_RC      2
`define CSR_RWI     3
`define CSR_RSI     4
`define CSR_RCI     5

`define MUL_MUL     0
`define MUL_MULH    1
`define MUL_MULHSU  2
`define MUL_MULHU   3

`define DIV_DIV     0
`define DIV_DIVU    1
`define DIV_REM     2
`define DIV_REMU    3

`endif

// File: rtl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [4:0] reg_addr_t;

  // Register-register layout.
  // The S, B, U and J immediates are cut from these same fields.
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_fmt_t;

  // Immediate layout.
  // The upper field is also the CSR address and the system code.
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
  } instr_word_t;

endpackage

`default_nettype wire

// File: rtl/decode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module decode_ctrl (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       instr_valid,
  input  rv_decode_pkg::instr_word_t instr,
  output logic                       sys_csr_imm,
  output logic                       dec_valid,
  output logic                       illegal,
  output logic                       alunit,
  output logic                       auipc,
  output logic                       lui,
  output logic                       jal,
  output logic                       jalr,
  output logic                       branch,
  output logic                       load,
  output logic                       store,
  output logic                       nop,
  output logic                       csreg,
  output logic                       mult,
  output logic                       division,
  output logic                       fence,
  output logic                       ecall,
  output logic                       ebreak,
  output logic                       mret,
  output logic                       wfi,
  output logic [`ALU_OP_W-1:0]       alu_op,
  output logic [`BCU_OP_W-1:0]       bcu_op,
  output logic [`LSU_OP_W-1:0]       lsu_op,
  output logic [`CSR_OP_W-1:0]       csr_op,
  output logic [`MUL_OP_W-1:0]       mul_op,
  output logic [`DIV_OP_W-1:0]       div_op
);

  import rv_decode_pkg::*;

  r_fmt_t rf;
  i_fmt_t iv;

  logic illegal_c;
  logic alunit_c, auipc_c, lui_c, jal_c, jalr_c, branch_c;
  logic load_c, store_c, nop_c, csreg_c, mult_c, division_c;
  logic fence_c, ecall_c, ebreak_c, mret_c, wfi_c;

  logic [`ALU_OP_W-1:0] alu_op_c;
  logic [`BCU_OP_W-1:0] bcu_op_c;
  logic [`LSU_OP_W-1:0] lsu_op_c;
  logic [`CSR_OP_W-1:0] csr_op_c;
  logic [`MUL_OP_W-1:0] mul_op_c;
  logic [`DIV_OP_W-1:0] div_op_c;

  assign rf = instr.r_view;
  assign iv = instr.i_view;

  // Immediate CSR forms carry a uimm in the rs1 field.
  assign sys_csr_imm = (rf.opcode == `OPC_SYSTEM) &&
                       (rf.funct3 inside {`F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI});

  always_comb begin
    illegal_c = 1'b0;
    {alunit_c, auipc_c, lui_c, jal_c, jalr_c, branch_c, load_c, store_c, nop_c,
     csreg_c, mult_c, division_c, fence_c, ecall_c, ebreak_c, mret_c, wfi_c} = 17'h0;
    alu_op_c = '0;
    bcu_op_c = '0;
    lsu_op_c = '0;
    csr_op_c = '0;
    mul_op_c = '0;
    div_op_c = '0;

    case (rf.opcode)
      `OPC_LUI:   lui_c   = 1'b1;
      `OPC_AUIPC: auipc_c = 1'b1;
      `OPC_JAL:   jal_c   = 1'b1;
      `OPC_JALR:  jalr_c  = 1'b1;
      `OPC_BRANCH: begin
        case (rf.funct3)
          `F3_BEQ:  bcu_op_c[`BCU_BEQ]  = 1'b1;
          `F3_BNE:  bcu_op_c[`BCU_BNE]  = 1'b1;
          `F3_BLT:  bcu_op_c[`BCU_BLT]  = 1'b1;
          `F3_BGE:  bcu_op_c[`BCU_BGE]  = 1'b1;
          `F3_BLTU: bcu_op_c[`BCU_BLTU] = 1'b1;
          `F3_BGEU: bcu_op_c[`BCU_BGEU] = 1'b1;
          default:  illegal_c = 1'b1;
        endcase
        branch_c = ~illegal_c;
      end
      `OPC_LOAD: begin
        case (rf.funct3)
          `F3_B:   lsu_op_c[`LSU_LB]  = 1'b1;
          `F3_H:   lsu_op_c[`LSU_LH]  = 1'b1;
          `F3_W:   lsu_op_c[`LSU_LW]  = 1'b1;
          `F3_BU:  lsu_op_c[`LSU_LBU] = 1'b1;
          `F3_HU:  lsu_op_c[`LSU_LHU] = 1'b1;
          default: illegal_c = 1'b1;
        endcase
        load_c = ~illegal_c;
      end
      `OPC_STORE: begin
        case (rf.funct3)
          `F3_B:   lsu_op_c[`LSU_SB] = 1'b1;
          `F3_H:   lsu_op_c[`LSU_SH] = 1'b1;
          `F3_W:   lsu_op_c[`LSU_SW] = 1'b1;
          default: illegal_c = 1'b1;
        endcase
        store_c = ~illegal_c;
      end
      `OPC_IMM: begin
        case (rf.funct3)
          `F3_ADD:  alu_op_c[`ALU_ADD]  = 1'b1;
          `F3_SLT:  alu_op_c[`ALU_SLT]  = 1'b1;
          `F3_SLTU: alu_op_c[`ALU_SLTU] = 1'b1;
          `F3_XOR:  alu_op_c[`ALU_XOR]  = 1'b1;
          `F3_OR:   alu_op_c[`ALU_OR]   = 1'b1;
          `F3_AND:  alu_op_c[`ALU_AND]  = 1'b1;
          // Shifts keep funct7 in the upper immediate bits.
          `F3_SLL: begin
            if (rf.funct7 == `F7_BASE) alu_op_c[`ALU_SLL] = 1'b1;
            else illegal_c = 1'b1;
          end
          `F3_SRL: begin
            if (rf.funct7 == `F7_BASE) alu_op_c[`ALU_SRL] = 1'b1;
            else if (rf.funct7 == `F7_ALT) alu_op_c[`ALU_SRA] = 1'b1;
            else illegal_c = 1'b1;
          end
          default: illegal_c = 1'b1;
        endcase
        alunit_c = ~illegal_c;
      end
      `OPC_REG: begin
        case (rf.funct7)
          `F7_BASE: begin
            case (rf.funct3)
              `F3_ADD:  alu_op_c[`ALU_ADD]  = 1'b1;
              `F3_SLL:  alu_op_c[`ALU_SLL]  = 1'b1;
              `F3_SLT:  alu_op_c[`ALU_SLT]  = 1'b1;
              `F3_SLTU: alu_op_c[`ALU_SLTU] = 1'b1;
              `F3_XOR:  alu_op_c[`ALU_XOR]  = 1'b1;
              `F3_SRL:  alu_op_c[`ALU_SRL]  = 1'b1;
              `F3_OR:   alu_op_c[`ALU_OR]   = 1'b1;
              default:  alu_op_c[`ALU_AND]  = 1'b1;
            endcase
            alunit_c = 1'b1;
          end
          `F7_ALT: begin
            case (rf.funct3)
              `F3_ADD: alu_op_c[`ALU_SUB] = 1'b1;
              `F3_SRL: alu_op_c[`ALU_SRA] = 1'b1;
              default: illegal_c = 1'b1;
            endcase
            alunit_c = ~illegal_c;
          end
          `F7_MULDIV: begin
            case (rf.funct3)
              `F3_MUL:    mul_op_c[`MUL_MUL]    = 1'b1;
              `F3_MULH:   mul_op_c[`MUL_MULH]   = 1'b1;
              `F3_MULHSU: mul_op_c[`MUL_MULHSU] = 1'b1;
              `F3_MULHU:  mul_op_c[`MUL_MULHU]  = 1'b1;
              `F3_DIV:    div_op_c[`DIV_DIV]    = 1'b1;
              `F3_DIVU:   div_op_c[`DIV_DIVU]   = 1'b1;
              `F3_REM:    div_op_c[`DIV_REM]    = 1'b1;
              default:    div_op_c[`DIV_REMU]   = 1'b1;
            endcase
            mult_c     = |mul_op_c;
            division_c = |div_op_c;
          end
          default: illegal_c = 1'b1;
        endcase
      end
      `OPC_FENCE: begin
        if (rf.funct3 == `F3_FENCE || rf.funct3 == `F3_FENCE_I) fence_c = 1'b1;
        else illegal_c = 1'b1;
      end
      `OPC_SYSTEM: begin
        case (rf.funct3)
          `F3_PRIV: begin
            case (iv.imm)
              `SYS_ECALL:  ecall_c  = 1'b1;
              `SYS_EBREAK: ebreak_c = 1'b1;
              `SYS_MRET:   mret_c   = 1'b1;
              `SYS_WFI:    wfi_c    = 1'b1;
              default:     illegal_c = 1'b1;
            endcase
          end
          `F3_CSRRW:  csr_op_c[`CSR_RW]  = 1'b1;
          `F3_CSRRS:  csr_op_c[`CSR_RS]  = 1'b1;
          `F3_CSRRC:  csr_op_c[`CSR_RC]  = 1'b1;
          `F3_CSRRWI: csr_op_c[`CSR_RWI] = 1'b1;
          `F3_CSRRSI: csr_op_c[`CSR_RSI] = 1'b1;
          `F3_CSRRCI: csr_op_c[`CSR_RCI] = 1'b1;
          // Funct3 of 4 leaves everything clear, illegal included
          default: ;
        endcase
        csreg_c = |csr_op_c;
      end
      default: illegal_c = 1'b1;
    endcase

    // The nop stays an ALU instruction but drives no ALU operation.
    if (instr == `NOP_INSTR) begin
      nop_c = 1'b1;
      alu_op_c[`ALU_ADD] = 1'b0;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
      illegal   <= 1'b0;
      {alunit, auipc, lui, jal, jalr, branch, load, store, nop,
       csreg, mult, division, fence, ecall, ebreak, mret, wfi} <= 17'h0;
      alu_op <= '0;
      bcu_op <= '0;
      lsu_op <= '0;
      csr_op <= '0;
      mul_op <= '0;
      div_op <= '0;
    end else begin
      dec_valid <= instr_valid;
      if (instr_valid) begin
        illegal <= illegal_c;
        {alunit, auipc, lui, jal, jalr, branch, load, store, nop,
         csreg, mult, division, fence, ecall, ebreak, mret, wfi} <=
          {alunit_c, auipc_c, lui_c, jal_c, jalr_c, branch_c, load_c, store_c, nop_c,
           csreg_c, mult_c, division_c, fence_c, ecall_c, ebreak_c, mret_c, wfi_c};
        alu_op <= alu_op_c;
        bcu_op <= bcu_op_c;
        lsu_op <= lsu_op_c;
        csr_op <= csr_op_c;
        mul_op <= mul_op_c;
        div_op <= div_op_c;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/operand_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module operand_ctrl (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       instr_valid,
  input  rv_decode_pkg::instr_word_t instr,
  input  logic                       sys_csr_imm,
  output logic [31:0]                imm,
  output logic                       wren,
  output logic                       rden1,
  output logic                       rden2,
  output logic                       cwren,
  output logic                       crden
);

  import rv_decode_pkg::*;

  r_fmt_t rf;
  i_fmt_t iv;

  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm_c;
  logic [31:0] imm_c_sel;
  logic        rd_nz, rs1_nz;
  logic        wren_c, rden1_c, rden2_c, cwren_c, crden_c;

  assign rf = instr.r_view;
  assign iv = instr.i_view;

  assign rd_nz  = |rf.rd;
  assign rs1_nz = |rf.rs1;

  assign imm_i = {{20{iv.imm[11]}}, iv.imm};
  assign imm_s = {{20{rf.funct7[6]}}, rf.funct7, rf.rd};
  assign imm_b = {{20{rf.funct7[6]}}, rf.rd[0], rf.funct7[5:0], rf.rd[4:1], 1'b0};
  assign imm_u = {rf.funct7, rf.rs2, rf.rs1, rf.funct3, 12'h000};
  assign imm_j = {{12{rf.funct7[6]}}, rf.rs1, rf.funct3, rf.rs2[0],
                  rf.funct7[5:0], rf.rs2[4:1], 1'b0};
  assign imm_c = {27'h0, rf.rs1};

  always_comb begin
    imm_c_sel = 32'h0;
    wren_c    = 1'b0;
    rden1_c   = 1'b0;
    rden2_c   = 1'b0;
    cwren_c   = 1'b0;
    crden_c   = 1'b0;

    case (rf.opcode)
      `OPC_LUI, `OPC_AUIPC: begin
        imm_c_sel = imm_u;
        wren_c    = rd_nz;
      end
      `OPC_JAL: begin
        imm_c_sel = imm_j;
        wren_c    = rd_nz;
      end
      `OPC_JALR, `OPC_LOAD, `OPC_IMM: begin
        imm_c_sel = imm_i;
        wren_c    = rd_nz;
        rden1_c   = 1'b1;
      end
      `OPC_STORE: begin
        imm_c_sel = imm_s;
        rden1_c   = 1'b1;
        rden2_c   = 1'b1;
      end
      `OPC_BRANCH: begin
        imm_c_sel = imm_b;
        rden1_c   = 1'b1;
        rden2_c   = 1'b1;
      end
      `OPC_REG: begin
        wren_c  = rd_nz;
        rden1_c = 1'b1;
        rden2_c = 1'b1;
      end
      `OPC_SYSTEM: begin
        imm_c_sel = imm_c;
        case (rf.funct3)
          // A write with rd of x0 skips the CSR read.
          `F3_CSRRW, `F3_CSRRWI: begin
            wren_c  = rd_nz;
            rden1_c = ~sys_csr_imm;
            cwren_c = 1'b1;
            crden_c = rd_nz;
          end
          // Set and clear with a zero source leave the CSR unwritten.
          // The uimm sits in the rs1 field.
          `F3_CSRRS, `F3_CSRRC, `F3_CSRRSI, `F3_CSRRCI: begin
            wren_c  = rd_nz;
            rden1_c = ~sys_csr_imm;
            cwren_c = rs1_nz;
            crden_c = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      imm   <= 32'h0;
      wren  <= 1'b0;
      rden1 <= 1'b0;
      rden2 <= 1'b0;
      cwren <= 1'b0;
      crden <= 1'b0;
    end else if (instr_valid) begin
      imm   <= imm_c_sel;
      wren  <= wren_c;
      rden1 <= rden1_c;
      rden2 <= rden2_c;
      cwren <= cwren_c;
      crden <= crden_c;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module rv_decoder (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       instr_valid,
  input  rv_decode_pkg::instr_word_t instr,
  output logic                       dec_valid,
  output logic                       illegal,
  output logic                       alunit,
  output logic                       auipc,
  output logic                       lui,
  output logic                       jal,
  output logic                       jalr,
  output logic                       branch,
  output logic                       load,
  output logic                       store,
  output logic                       nop,
  output logic                       csreg,
  output logic                       mult,
  output logic                       division,
  output logic                       fence,
  output logic                       ecall,
  output logic                       ebreak,
  output logic                       mret,
  output logic                       wfi,
  output logic [`ALU_OP_W-1:0]       alu_op,
  output logic [`BCU_OP_W-1:0]       bcu_op,
  output logic [`LSU_OP_W-1:0]       lsu_op,
  output logic [`CSR_OP_W-1:0]       csr_op,
  output logic [`MUL_OP_W-1:0]       mul_op,
  output logic [`DIV_OP_W-1:0]       div_op,
  output logic [31:0]                imm,
  output logic                       wren,
  output logic                       rden1,
  output logic                       rden2,
  output logic                       cwren,
  output logic                       crden
);

  // Immediate CSR class, passed across unregistered.
  logic sys_csr_imm;

  decode_ctrl u_decode_ctrl (.*);

  operand_ctrl u_operand_ctrl (.*);

endmodule

`default_nettype wire

// File: verif/tb_rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module tb_rv_decoder;

  import rv_decode_pkg::*;

  localparam int MAX_PAT   = 128;
  localparam int PAT_WORDS = 4;
  localparam int MEM_DEPTH = MAX_PAT * PAT_WORDS;

  logic        clock;
  logic        arst_n;
  logic        instr_valid;
  instr_word_t instr;

  logic                 dec_valid;
  logic                 illegal;
  logic                 alunit, auipc, lui, jal, jalr, branch, load, store, nop;
  logic                 csreg, mult, division, fence, ecall, ebreak, mret, wfi;
  logic [`ALU_OP_W-1:0] alu_op;
  logic [`BCU_OP_W-1:0] bcu_op;
  logic [`LSU_OP_W-1:0] lsu_op;
  logic [`CSR_OP_W-1:0] csr_op;
  logic [`MUL_OP_W-1:0] mul_op;
  logic [`DIV_OP_W-1:0] div_op;
  logic [31:0]          imm;
  logic                 wren, rden1, rden2, cwren, crden;

  // Four words per pattern: instruction, imm, control word, operation vectors.
  logic [39:0] pat_mem [0:MEM_DEPTH-1];

  int          num_pat;
  int          exp_q [$];
  logic [31:0] lfsr;
  logic [31:0] hold_imm;
  logic [22:0] hold_ctrl;
  logic [37:0] hold_ops;

  // Control word bits from 22 down to 0.
  string ctrl_names [0:22] = '{
    "illegal", "alunit", "auipc", "lui", "jal", "jalr", "branch", "load",
    "store", "nop", "csreg", "mult", "division", "fence", "ecall", "ebreak",
    "mret", "wfi", "wren", "rden1", "rden2", "cwren", "crden"
  };

  rv_decoder dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 32'hb4bcd35c;
    end
    return shifted;
  endfunction

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_field(input string name, input logic [39:0] act,
                               input logic [39:0] exp);
    assert (act === exp) else begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
      stop_with_failure();
    end
  endtask

  // Waits for the next edge and checks the result that it produced.
  task automatic advance_and_check();
    logic [22:0] ctrl_act;
    int          idx;
    int          b;
    @(posedge clock);
    #1;
    // instr_valid still holds the value that the edge sampled.
    if (instr_valid) begin
      idx       = exp_q.pop_front();
      hold_imm  = pat_mem[idx*PAT_WORDS+1][31:0];
      hold_ctrl = pat_mem[idx*PAT_WORDS+2][22:0];
      hold_ops  = pat_mem[idx*PAT_WORDS+3][37:0];
    end
    compare_field("dec_valid", 40'(dec_valid), 40'(instr_valid));
    ctrl_act = {illegal, alunit, auipc, lui, jal, jalr, branch, load, store, nop,
                csreg, mult, division, fence, ecall, ebreak, mret, wfi,
                wren, rden1, rden2, cwren, crden};
    compare_field("imm", 40'(imm), 40'(hold_imm));
    for (b = 22; b >= 0; b--) begin
      compare_field(ctrl_names[22-b], 40'(ctrl_act[b]), 40'(hold_ctrl[b]));
    end
    compare_field("alu_op", 40'(alu_op), 40'(hold_ops[37:28]));
    compare_field("bcu_op", 40'(bcu_op), 40'(hold_ops[27:22]));
    compare_field("lsu_op", 40'(lsu_op), 40'(hold_ops[21:14]));
    compare_field("csr_op", 40'(csr_op), 40'(hold_ops[13:8]));
    compare_field("mul_op", 40'(mul_op), 40'(hold_ops[7:4]));
    compare_field("div_op", 40'(div_op), 40'(hold_ops[3:0]));
  endtask

  initial begin : watchdog
    wait (num_pat > 0);
    repeat (num_pat * 5 + 20) @(posedge clock);
    $display("Timeout: decoder results did not all arrive within %0d cycles",
             num_pat * 5 + 20);
    stop_with_failure();
  end

  initial begin : stimulus
    int         i;
    int         k;
    int         n;
    logic [1:0] gap;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = 32'h98c;
    hold_imm    = '0;
    hold_ctrl   = '0;
    hold_ops    = '0;
    // Bits above 31 are set in every entry that the file leaves unfilled.
    for (i = 0; i < MEM_DEPTH; i++) begin
      pat_mem[i] = {8'hff, 32'(i)};
    end
    $readmemh("verif/decode_patterns.hex", pat_mem);
    n = 0;
    while (n < MAX_PAT && pat_mem[n*PAT_WORDS][39:32] == 8'h00) begin
      n = n + 1;
    end
    num_pat = n;
    assert (num_pat > 0) else begin
      $display("No patterns were read from verif/decode_patterns.hex");
      stop_with_failure();
    end

    repeat (3) @(posedge clock);
    #1;
    arst_n = 1'b1;

    // Reset state, before any strobe.
    repeat (2) begin
      advance_and_check();
    end

    for (k = 0; k < num_pat; k++) begin
      gap = 2'b00;
      repeat (2) begin
        lfsr = lfsr_next(lfsr);
        gap  = {gap[0], lfsr[0]};
      end
      // Junk on the bus while idle must not reach the outputs.
      repeat (gap) begin
        advance_and_check();
        instr_valid = 1'b0;
        instr       = 32'hffffffff;
      end
      advance_and_check();
      instr_valid = 1'b1;
      instr       = pat_mem[k*PAT_WORDS][31:0];
      exp_q.push_back(k);
    end

    advance_and_check();
    instr_valid = 1'b0;
    instr       = 32'hffffffff;
    advance_and_check();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/decode_patterns.hex
// instr, imm, control {illegal, 17 class flags, wren, rden1, rden2, cwren, crden},
// operations {alu[37:28], bcu[27:22], lsu[21:14], csr[13:8], mul[7:4], div[3:0]}
123450b7 12345000 080010 0000000000 // lui x1
fedcb2b7 fedcb000 080010 0000000000 // lui x5, sign set
00001017 00001000 100000 0000000000 // auipc x0
001000ef 00000800 040010 0000000000 // jal x1, +0x800
fffff06f fffffffe 040000 0000000000 // jal x0, -2
ffc100e7 fffffffc 020018 0000000000 // jalr x1, -4(x2)
00310463 00000008 01000c 0000400000 // beq +8
fe311ce3 fffffff8 01000c 0000800000 // bne -8
003140e3 00000800 01000c 0001000000 // blt +0x800
00315863 00000010 01000c 0002000000 // bge +16
02316063 00000020 01000c 0004000000 // bltu +32
00317263 00000004 01000c 0008000000 // bgeu +4
00410083 00000004 008018 0000004000 // lb x1, 4(x2)
fff11003 ffffffff 008008 0000008000 // lh x0, -1(x2)
7ff12083 000007ff 008018 0000010000 // lw x1, 0x7ff(x2)
00014083 00000000 008018 0000020000 // lbu x1, 0(x2)
80015083 fffff800 008018 0000040000 // lhu x1, -2048(x2)
003102a3 00000005 00400c 0000080000 // sb x3, 5(x2)
fe311023 ffffffe0 00400c 0000100000 // sh x3, -32(x2)
7e3120a3 000007e1 00400c 0000200000 // sw x3, 0x7e1(x2)
fff10093 ffffffff 200018 0010000000 // addi x1, x2, -1
00510013 00000005 200008 0010000000 // addi x0, x2, 5
00a12093 0000000a 200018 0080000000 // slti
00113093 00000001 200018 0100000000 // sltiu
55514093 00000555 200018 0200000000 // xori
f0016093 ffffff00 200018 1000000000 // ori
0ff17093 000000ff 200018 2000000000 // andi
00311093 00000003 200018 0040000000 // slli
00715093 00000007 200018 0400000000 // srli
40715093 00000407 200018 0800000000 // srai
003100b3 00000000 20001c 0010000000 // add x1
00310033 00000000 20000c 0010000000 // add x0
403100b3 00000000 20001c 0020000000 // sub
003110b3 00000000 20001c 0040000000 // sll
003120b3 00000000 20001c 0080000000 // slt
003130b3 00000000 20001c 0100000000 // sltu
003140b3 00000000 20001c 0200000000 // xor
003150b3 00000000 20001c 0400000000 // srl
403150b3 00000000 20001c 0800000000 // sra
003160b3 00000000 20001c 1000000000 // or
003170b3 00000000 20001c 2000000000 // and
023100b3 00000000 00081c 0000000010 // mul
023110b3 00000000 00081c 0000000020 // mulh
023120b3 00000000 00081c 0000000040 // mulhsu
023130b3 00000000 00081c 0000000080 // mulhu
023140b3 00000000 00041c 0000000001 // div
023150b3 00000000 00041c 0000000002 // divu
023160b3 00000000 00041c 0000000004 // rem
023170b3 00000000 00041c 0000000008 // remu
0ff0000f 00000000 000200 0000000000 // fence
00000073 00000000 000100 0000000000 // ecall
00100073 00000000 000080 0000000000 // ebreak
30200073 00000000 000040 0000000000 // mret
10500073 00000000 000020 0000000000 // wfi
300110f3 00000002 00101b 0000000100 // csrrw x1, x2
30011073 00000002 00100a 0000000100 // csrrw x0, x2
300020f3 00000000 001019 0000000200 // csrrs x1, x0
300120f3 00000002 00101b 0000000200 // csrrs x1, x2
300130f3 00000002 00101b 0000000400 // csrrc x1, x2
30003073 00000000 001009 0000000400 // csrrc x0, x0
300fd0f3 0000001f 001013 0000000800 // csrrwi x1, 31
300060f3 00000000 001011 0000001000 // csrrsi x1, 0
3002e0f3 00000005 001013 0000001000 // csrrsi x1, 5
300870f3 00000010 001013 0000002000 // csrrci x1, 16
300070f3 00000000 001011 0000002000 // csrrci x1, 0
00000013 00000000 202008 0000000000 // nop
60011093 00000600 400018 0000000000 // clz, Zbb
403170b3 00000000 40001c 0000000000 // andn, Zbb
0a3110b3 00000000 40001c 0000000000 // clmul, Zbc
203120b3 00000000 40001c 0000000000 // sh1add, Zba
00312063 00000000 40000c 0000000000 // branch with funct3 2
ffffffff 00000000 400000 0000000000 // unknown opcode
00004073 00000000 000000 0000000000 // system funct3 4, nothing set

// File: filelist.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/decode_ctrl.sv
rtl/operand_ctrl.sv
rtl/rv_decoder.sv
verif/tb_rv_decoder.sv

// File: Makefile
TOP := tb_rv_decoder

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f rtl/*.sv rtl/*.svh verif/*.sv
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f filelist.f \
		--top-module rv_decoder

clean:
	rm -rf obj_dir sim.log
